// File: common/cpu_pkg.sv
package cpu_pkg;

  // Datapath and register file sizes
  localparam int data_bits   = 32;
  localparam int reg_no_bits = 4;
  localparam int imm_bits    = 16;

  localparam logic [data_bits-1:0] start_pc = 32'h0000_0100;

  localparam int imem_words = 16384;
  localparam int dmem_words = 16384;

  // Memory-mapped I/O
  localparam logic [data_bits-1:0] addr_hex  = 32'hFFFF_F000;
  localparam logic [data_bits-1:0] addr_ledr = 32'hFFFF_F020;
  localparam logic [data_bits-1:0] addr_key  = 32'hFFFF_F080;

  localparam int hex_bits  = 24;
  localparam int ledr_bits = 10;
  localparam int key_bits  = 4;

  localparam logic [hex_bits-1:0] hex_reset = 24'hFEDEAD;

  // Primary opcode, instr[31:26]
  typedef enum logic [5:0] {
    op1_alur = 6'b000000,
    op1_beq  = 6'b001000,
    op1_blt  = 6'b001001,
    op1_ble  = 6'b001010,
    op1_bne  = 6'b001011,
    op1_jal  = 6'b001100,
    op1_lw   = 6'b010010,
    op1_sw   = 6'b011010,
    op1_addi = 6'b100000,
    op1_andi = 6'b100100,
    op1_ori  = 6'b100101,
    op1_xori = 6'b100110
  } op1_t;

  // Secondary ALU op, instr[25:18] when op1 is alur
  typedef enum logic [7:0] {
    op2_eq   = 8'b00001000,
    op2_lt   = 8'b00001001,
    op2_le   = 8'b00001010,
    op2_ne   = 8'b00001011,
    op2_add  = 8'b00100000,
    op2_and  = 8'b00100100,
    op2_or   = 8'b00100101,
    op2_xor  = 8'b00100110,
    op2_sub  = 8'b00101000,
    op2_nand = 8'b00101100,
    op2_nor  = 8'b00101101,
    op2_nxor = 8'b00101110,
    op2_rshf = 8'b00110000,
    op2_lshf = 8'b00110001
  } op2_t;

  typedef enum logic [1:0] {
    src_rt   = 2'b00,  // Register rt contents
    src_imm  = 2'b01,
    src_imm4 = 2'b10   // Immediate times 4
  } alu_src_t;

  typedef enum logic [1:0] {
    wr_pc  = 2'b00,
    wr_mem = 2'b01,
    wr_alu = 2'b10
  } wr_src_t;

  typedef struct packed {
    logic                 valid;
    logic [data_bits-1:0] pc_next;  // PC plus 4
    logic [data_bits-1:0] instr;
  } fetch_out_t;

  typedef struct packed {
    logic                   valid;
    logic [data_bits-1:0]   pc_next;
    op1_t                   op1;
    op2_t                   op2;
    logic [data_bits-1:0]   rs_val;
    logic [data_bits-1:0]   rt_val;
    logic [data_bits-1:0]   sxt_imm;
    logic [reg_no_bits-1:0] dst;
    alu_src_t               alu_src;
    logic                   mem_we;
    logic                   mem_re;
    logic                   reg_we;
    wr_src_t                wr_src;
  } decode_out_t;

  typedef struct packed {
    logic                   valid;
    logic [data_bits-1:0]   pc_next;
    logic [data_bits-1:0]   alu_out;
    logic [data_bits-1:0]   rt_val;  // Store data
    logic [reg_no_bits-1:0] dst;
    logic                   mem_we;
    logic                   mem_re;
    logic                   reg_we;
    wr_src_t                wr_src;
  } exec_out_t;

  typedef struct packed {
    logic                   we;
    logic [reg_no_bits-1:0] dst;
    logic [data_bits-1:0]   data;
  } wb_t;

  typedef struct packed {
    logic                 taken;
    logic [data_bits-1:0] target;
  } redirect_t;

endpackage

// File: fetch/fetch_stage.sv
module fetch_stage (
  input  logic                clk,
  input  logic                reset,
  input  logic                hold,
  input  cpu_pkg::redirect_t  redirect,
  output cpu_pkg::fetch_out_t fetch_out
);
  import cpu_pkg::*;

  logic [data_bits-1:0] imem [imem_words];
  logic [data_bits-1:0] pc;
  logic [data_bits-1:0] pc_plus4;
  logic [data_bits-1:0] instr;

  // Program image
  initial begin
    $readmemh("tb/prog.hex", imem);
  end

  assign pc_plus4 = pc + 32'd4;
  assign instr    = imem[pc[$clog2(imem_words)+1:2]];  // Word addressed

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc        <= start_pc;
      fetch_out <= '0;
    end else if (redirect.taken) begin
      // Resolved branch or JAL wins over hold
      pc        <= redirect.target;
      fetch_out <= '0;
    end else if (!hold) begin
      pc        <= pc_plus4;
      fetch_out <= '{valid: 1'b1, pc_next: pc_plus4, instr: instr};
    end
  end

  // Branch targets are scaled by 4, so the PC never loses word alignment
  pc_aligned_a: assert property (
    @(posedge clk) disable iff (reset) pc[1:0] == 2'b00
  );

endmodule

// File: decode/decode_stage.sv
module decode_stage (
  input  logic                 clk,
  input  logic                 reset,
  input  cpu_pkg::fetch_out_t  fetch_in,
  input  cpu_pkg::exec_out_t   ex_buf,
  input  cpu_pkg::redirect_t   redirect,
  input  cpu_pkg::wb_t         wb,
  output logic                 hold,
  output cpu_pkg::decode_out_t decode_out
);
  import cpu_pkg::*;

  logic [data_bits-1:0]   regs [2**reg_no_bits];
  op1_t                   op1;
  op2_t                   op2;
  logic [imm_bits-1:0]    imm;
  logic [reg_no_bits-1:0] rd, rs, rt, dst;
  logic [data_bits-1:0]   rs_val, rt_val, sxt_imm;
  alu_src_t               alu_src;
  wr_src_t                wr_src;
  logic                   mem_we, mem_re, reg_we, reads_rt;
  logic                   fetch_used;  // Fetch buffer entry already decoded
  logic                   fetch_valid, rs_hit, rt_hit, stall;

  function automatic logic is_flow(input op1_t op);
    return op inside {op1_beq, op1_blt, op1_ble, op1_bne, op1_jal};
  endfunction

  assign fetch_valid = fetch_in.valid && !fetch_used;
  assign op1 = op1_t'(fetch_in.instr[31:26]);
  assign op2 = op2_t'(fetch_in.instr[25:18]);
  assign imm = fetch_in.instr[23:8];
  assign rd  = fetch_in.instr[11:8];
  assign rs  = fetch_in.instr[7:4];
  assign rt  = fetch_in.instr[3:0];
  assign sxt_imm = {{(data_bits-imm_bits){imm[imm_bits-1]}}, imm};

  // Register reads see a write landing at the same edge
  assign rs_val = (wb.we && wb.dst == rs) ? wb.data : regs[rs];
  assign rt_val = (wb.we && wb.dst == rt) ? wb.data : regs[rt];

  always_comb begin
    alu_src  = src_imm;
    wr_src   = wr_alu;
    mem_we   = 1'b0;
    mem_re   = 1'b0;
    reg_we   = 1'b0;
    reads_rt = 1'b0;
    dst      = rt;
    case (op1)
      op1_alur: begin
        alu_src  = src_rt;
        reg_we   = 1'b1;
        reads_rt = 1'b1;
        dst      = rd;
      end
      op1_beq, op1_blt, op1_ble, op1_bne: begin
        alu_src  = src_rt;
        reads_rt = 1'b1;
      end
      op1_jal: begin
        alu_src = src_imm4;  // Target is rs + imm*4
        wr_src  = wr_pc;     // Link register gets pc_next
        reg_we  = 1'b1;
      end
      op1_lw: begin
        mem_re = 1'b1;
        wr_src = wr_mem;
        reg_we = 1'b1;
      end
      op1_sw: begin
        mem_we   = 1'b1;
        reads_rt = 1'b1;  // Store data
      end
      op1_addi, op1_andi, op1_ori, op1_xori: reg_we = 1'b1;
      default: ;
    endcase
  end

  // Pending writers still in the decode or execute buffer
  assign rs_hit = (decode_out.valid && decode_out.reg_we && decode_out.dst == rs) ||
                  (ex_buf.valid && ex_buf.reg_we && ex_buf.dst == rs);
  assign rt_hit = (decode_out.valid && decode_out.reg_we && decode_out.dst == rt) ||
                  (ex_buf.valid && ex_buf.reg_we && ex_buf.dst == rt);

  assign stall = (fetch_valid && (rs_hit || (reads_rt && rt_hit))) ||
                 (decode_out.valid && is_flow(decode_out.op1));
  assign hold  = stall || (fetch_valid && is_flow(op1));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < 2**reg_no_bits; i++)
        regs[i] <= '0;
    end else if (wb.we) begin
      regs[wb.dst] <= wb.data;
    end
  end

  // Fetch keeps a branch in its buffer while decode passes it on
  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      fetch_used <= 1'b0;
    else if (redirect.taken || !hold)
      fetch_used <= 1'b0;
    else if (!stall && fetch_valid)
      fetch_used <= 1'b1;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      decode_out <= '0;
    else if (redirect.taken || stall || !fetch_valid)
      decode_out <= '0;  // Bubble
    else
      decode_out <= '{valid: 1'b1, pc_next: fetch_in.pc_next, op1: op1, op2: op2,
                      rs_val: rs_val, rt_val: rt_val, sxt_imm: sxt_imm, dst: dst,
                      alu_src: alu_src, mem_we: mem_we, mem_re: mem_re,
                      reg_we: reg_we, wr_src: wr_src};
  end

  wb_known_a: assert property (
    @(posedge clk) disable iff (reset) wb.we |-> !$isunknown({wb.dst, wb.data})
  );

  bubble_quiet_a: assert property (
    @(posedge clk) disable iff (reset)
      !decode_out.valid |-> !(decode_out.mem_we || decode_out.mem_re || decode_out.reg_we)
  );

endmodule

// File: execute/execute_stage.sv
module execute_stage (
  input  logic                 clk,
  input  logic                 reset,
  input  cpu_pkg::decode_out_t dec_in,
  output cpu_pkg::redirect_t   redirect,
  output cpu_pkg::exec_out_t   exec_out
);
  import cpu_pkg::*;

  logic [data_bits-1:0] a, b, imm4, alu_res;
  logic                 eq, lt, le;
  logic                 is_branch, is_jal;

  function automatic logic [data_bits-1:0] flag(input logic bit_in);
    return {{(data_bits-1){1'b0}}, bit_in};
  endfunction

  assign a    = dec_in.rs_val;
  assign imm4 = dec_in.sxt_imm << 2;

  always_comb begin
    case (dec_in.alu_src)
      src_imm:  b = dec_in.sxt_imm;
      src_imm4: b = imm4;
      default:  b = dec_in.rt_val;
    endcase
  end

  // Signed compares shared by ALU ops and branches
  assign eq = a == b;
  assign lt = $signed(a) < $signed(b);
  assign le = $signed(a) <= $signed(b);

  always_comb begin
    case (dec_in.op1)
      op1_alur: begin
        case (dec_in.op2)
          op2_eq:   alu_res = flag(eq);
          op2_lt:   alu_res = flag(lt);
          op2_le:   alu_res = flag(le);
          op2_ne:   alu_res = flag(!eq);
          op2_add:  alu_res = a + b;
          op2_and:  alu_res = a & b;
          op2_or:   alu_res = a | b;
          op2_xor:  alu_res = a ^ b;
          op2_sub:  alu_res = a - b;
          op2_nand: alu_res = ~(a & b);
          op2_nor:  alu_res = ~(a | b);
          op2_nxor: alu_res = ~(a ^ b);
          op2_rshf: alu_res = $signed(a) >>> b;  // Sign fill
          op2_lshf: alu_res = a << b;
          default:  alu_res = '0;
        endcase
      end
      op1_beq:  alu_res = flag(eq);
      op1_blt:  alu_res = flag(lt);
      op1_ble:  alu_res = flag(le);
      op1_bne:  alu_res = flag(!eq);
      op1_andi: alu_res = a & b;
      op1_ori:  alu_res = a | b;
      op1_xori: alu_res = a ^ b;
      default:  alu_res = a + b;  // addi, lw, sw and the JAL target
    endcase
  end

  assign is_branch = dec_in.op1 inside {op1_beq, op1_blt, op1_ble, op1_bne};
  assign is_jal    = dec_in.op1 == op1_jal;

  assign redirect.taken  = dec_in.valid && ((is_branch && alu_res[0]) || is_jal);
  assign redirect.target = is_jal ? alu_res : dec_in.pc_next + imm4;

  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      exec_out <= '0;
    else
      exec_out <= '{valid: dec_in.valid, pc_next: dec_in.pc_next, alu_out: alu_res,
                    rt_val: dec_in.rt_val, dst: dec_in.dst, mem_we: dec_in.mem_we,
                    mem_re: dec_in.mem_re, reg_we: dec_in.reg_we, wr_src: dec_in.wr_src};
  end

  // A bubble from decode must never steer fetch
  redirect_valid_a: assert property (
    @(posedge clk) disable iff (reset) redirect.taken |-> dec_in.valid
  );

endmodule

// File: verilog/mem_io_stage.sv
module mem_io_stage (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [cpu_pkg::key_bits-1:0]    key,
  input  cpu_pkg::exec_out_t              ex_in,
  output cpu_pkg::wb_t                    wb,
  output logic [cpu_pkg::hex_bits-1:0]    hex,
  output logic [cpu_pkg::ledr_bits-1:0]   ledr
);
  import cpu_pkg::*;

  logic [data_bits-1:0] dmem [dmem_words];
  logic [$clog2(dmem_words)-1:0] dmem_idx;
  logic                 is_hex, is_ledr, is_key;
  logic [data_bits-1:0] load_data;
  logic [data_bits-1:0] wr_data;

  assign dmem_idx = ex_in.alu_out[$clog2(dmem_words)+1:2];
  assign is_hex   = ex_in.alu_out == addr_hex;
  assign is_ledr  = ex_in.alu_out == addr_ledr;
  assign is_key   = ex_in.alu_out == addr_key;

  // Keys are active low on the board
  assign load_data = is_key ? {{(data_bits-key_bits){1'b0}}, ~key} : dmem[dmem_idx];

  always_ff @(posedge clk) begin
    if (ex_in.mem_we && !is_hex && !is_ledr && !is_key)
      dmem[dmem_idx] <= ex_in.rt_val;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hex  <= hex_reset;
      ledr <= '0;
    end else if (ex_in.mem_we) begin
      if (is_hex)
        hex <= ex_in.rt_val[hex_bits-1:0];
      if (is_ledr)
        ledr <= ex_in.rt_val[ledr_bits-1:0];
    end
  end

  always_comb begin
    case (ex_in.wr_src)
      wr_pc:   wr_data = ex_in.pc_next;  // JAL link
      wr_mem:  wr_data = load_data;
      default: wr_data = ex_in.alu_out;
    endcase
  end

  // Register file write happens one edge later, from this register
  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      wb <= '0;
    else
      wb <= '{we: ex_in.valid && ex_in.reg_we, dst: ex_in.dst, data: wr_data};
  end

  mem_excl_a: assert property (
    @(posedge clk) disable iff (reset) !(ex_in.mem_we && ex_in.mem_re)
  );

endmodule

// File: verilog/cpu_top.sv
module cpu_top (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [cpu_pkg::key_bits-1:0]  key,
  output logic [cpu_pkg::hex_bits-1:0]  hex,
  output logic [cpu_pkg::ledr_bits-1:0] ledr
);
  import cpu_pkg::*;

  fetch_out_t  fetch_buf;
  decode_out_t decode_buf;
  exec_out_t   exec_buf;
  wb_t         wb;
  redirect_t   redirect;   // From execute
  logic        hold;       // From decode

  fetch_stage u_fetch (
    .clk       (clk),
    .reset     (reset),
    .hold      (hold),
    .redirect  (redirect),
    .fetch_out (fetch_buf)
  );

  decode_stage u_decode (
    .clk        (clk),
    .reset      (reset),
    .fetch_in   (fetch_buf),
    .ex_buf     (exec_buf),
    .redirect   (redirect),
    .wb         (wb),
    .hold       (hold),
    .decode_out (decode_buf)
  );

  execute_stage u_execute (
    .clk      (clk),
    .reset    (reset),
    .dec_in   (decode_buf),
    .redirect (redirect),
    .exec_out (exec_buf)
  );

  mem_io_stage u_mem_io (
    .clk   (clk),
    .reset (reset),
    .key   (key),
    .ex_in (exec_buf),
    .wb    (wb),
    .hex   (hex),
    .ledr  (ledr)
  );

endmodule

// File: tb/ref_model.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// Model copies of instruction and data memory
logic [data_bits-1:0] ref_imem [imem_words];
logic [data_bits-1:0] ref_dmem [dmem_words];

// 32-bit xorshift step for the key value
function automatic logic [31:0] xorshift32(input logic [31:0] state);
  logic [31:0] x;
  x = state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

function automatic logic [31:0] alu_result(input logic [7:0] op, input logic [31:0] a,
                                           input logic [31:0] b);
  case (op)
    op2_eq:   return {31'b0, a == b};
    op2_lt:   return {31'b0, $signed(a) < $signed(b)};
    op2_le:   return {31'b0, $signed(a) <= $signed(b)};
    op2_ne:   return {31'b0, a != b};
    op2_add:  return a + b;
    op2_and:  return a & b;
    op2_or:   return a | b;
    op2_xor:  return a ^ b;
    op2_sub:  return a - b;
    op2_nand: return ~(a & b);
    op2_nor:  return ~(a | b);
    op2_nxor: return ~(a ^ b);
    op2_rshf: return $signed(a) >>> b;  // Sign fill
    op2_lshf: return a << b;
    default:  return 32'h0;
  endcase
endfunction

// Branch condition on rs against rt
function automatic logic branch_taken(input logic [5:0] op, input logic [31:0] a,
                                      input logic [31:0] b);
  case (op)
    op1_beq: return a == b;
    op1_blt: return $signed(a) < $signed(b);
    op1_ble: return $signed(a) <= $signed(b);
    default: return a != b;
  endcase
endfunction

// Runs the program to its self-branch; returns the instruction count, 0 if it never got there
function automatic int run_reference(input logic [key_bits-1:0] key_val);
  logic [31:0] regs [16];
  logic [31:0] instr, pc, pc_next, next_pc, a, b, imm, addr;
  logic [5:0]  op1;
  logic [7:0]  op2;
  logic [3:0]  rd, rs, rt;
  logic [ledr_bits-1:0] ledr_now;
  logic [hex_bits-1:0]  hex_now;
  logic done;
  int count;
  $readmemh("tb/prog.hex", ref_imem);
  foreach (regs[i]) regs[i] = '0;
  foreach (ref_dmem[i]) ref_dmem[i] = '0;
  pc = start_pc;
  ledr_now = '0;
  hex_now = hex_reset;
  done = 1'b0;
  count = 0;
  while (!done && count < 5000) begin
    instr = ref_imem[pc[15:2]];
    op1 = instr[31:26];
    op2 = instr[25:18];
    rd = instr[11:8];
    rs = instr[7:4];
    rt = instr[3:0];
    imm = {{16{instr[23]}}, instr[23:8]};
    a = regs[rs];
    b = regs[rt];
    addr = a + imm;
    pc_next = pc + 32'd4;
    next_pc = pc_next;
    count++;
    case (op1)
      op1_alur: regs[rd] = alu_result(op2, a, b);
      op1_beq, op1_blt, op1_ble, op1_bne: begin
        if (branch_taken(op1, a, b))
          next_pc = pc_next + (imm << 2);
      end
      op1_jal: begin
        regs[rt] = pc_next;  // Link
        next_pc = a + (imm << 2);
      end
      op1_lw: begin
        if (addr == addr_key)
          regs[rt] = {{(32-key_bits){1'b0}}, ~key_val};
        else
          regs[rt] = ref_dmem[addr[15:2]];  // 16K words
      end
      op1_sw: begin
        if (addr == addr_hex) begin
          if (b[hex_bits-1:0] != hex_now)
            exp_hex_q.push_back(b[hex_bits-1:0]);
          hex_now = b[hex_bits-1:0];
        end else if (addr == addr_ledr) begin
          if (b[ledr_bits-1:0] != ledr_now)
            exp_ledr_q.push_back(b[ledr_bits-1:0]);
          ledr_now = b[ledr_bits-1:0];
        end else if (addr != addr_key) begin
          ref_dmem[addr[15:2]] = b;
        end
      end
      op1_addi: regs[rt] = a + imm;
      op1_andi: regs[rt] = a & imm;
      op1_ori:  regs[rt] = a | imm;
      op1_xori: regs[rt] = a ^ imm;
      default:  return 0;  // Unknown opcode
    endcase
    if (next_pc == pc)
      done = 1'b1;
    pc = next_pc;
  end
  return done ? count : 0;
endfunction

`endif

// File: tb/tb_top.sv
module tb_top;
  timeunit 1ns;
  timeprecision 1ps;
  import cpu_pkg::*;

  logic                 clk;
  logic                 reset;
  logic [key_bits-1:0]  key;
  logic [hex_bits-1:0]  hex;
  logic [ledr_bits-1:0] ledr;

  // Expected output changes, in program order
  logic [ledr_bits-1:0] exp_ledr_q [$];
  logic [hex_bits-1:0]  exp_hex_q [$];
  int                   cycle_limit;
  int                   cycles;
  logic                 ref_ready;

  `include "ref_model.svh"

  cpu_top UUT (
    .clk   (clk),
    .reset (reset),
    .key   (key),
    .hex   (hex),
    .ledr  (ledr)
  );

  task automatic report_failure(input string reason);
    $display("%s", reason);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
      report_failure($sformatf("[ERROR] %0d ns: %s expected %h, actual %h",
                               $time, name, expected, actual));
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin : stimulus
    logic [31:0] seed;
    int          steps;
    reset = 1'b1;
    key = '0;
    ref_ready = 1'b0;
    cycle_limit = 0;
    seed = xorshift32(32'd59474);
    @(posedge clk);
    #2;
    key = seed[key_bits-1:0];  // Held for the whole run
    steps = run_reference(key);
    if (steps <= 0)
      report_failure("reference model hit an unknown opcode or never reached the self-branch");
    else
      cycle_limit = steps * 6 + 200;
    repeat (7) @(posedge clk);
    #2;
    reset = 1'b0;
    ref_ready = 1'b1;
  end

  initial begin : compare
    logic [ledr_bits-1:0] last_ledr;
    logic [hex_bits-1:0]  last_hex;
    logic [ledr_bits-1:0] want_ledr;
    logic [hex_bits-1:0]  want_hex;
    wait (ref_ready);
    @(posedge clk);
    #1;
    // Reset values before any store gets through
    check_value("ledr", 32'h0, 32'(ledr));
    check_value("hex", 32'h00FE_DEAD, 32'(hex));
    last_ledr = ledr;
    last_hex = hex;
    while (exp_ledr_q.size() > 0 || exp_hex_q.size() > 0) begin
      @(posedge clk);
      #1;
      if (ledr != last_ledr) begin
        if (exp_ledr_q.size() == 0) begin
          report_failure("ledr changed after its expected sequence ended");
        end else begin
          want_ledr = exp_ledr_q.pop_front();
          check_value("ledr", 32'(want_ledr), 32'(ledr));
          last_ledr = ledr;
        end
      end
      if (hex != last_hex) begin
        if (exp_hex_q.size() == 0) begin
          report_failure("hex changed after its expected sequence ended");
        end else begin
          want_hex = exp_hex_q.pop_front();
          check_value("hex", 32'(want_hex), 32'(hex));
          last_hex = hex;
        end
      end
    end
    // Program spins on its self-branch, outputs stay put
    repeat (20) begin
      @(posedge clk);
      #1;
      if (ledr != last_ledr || hex != last_hex)
        report_failure("ledr or hex changed after the last expected value");
    end
    $display(">>> PASS");
    $finish;
  end

  initial begin : watchdog
    wait (ref_ready);
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    report_failure("timeout: outputs did not finish");
  end

endmodule

// File: tb/prog.hex
// One 32-bit instruction word per column, placed from word index 0x40 (PC 0x100)
// R-type op2[25:18] rd[11:8] rs[7:4] rt[3:0], I-type op1[31:26] imm[23:8] rs[7:4] rt[3:0]
@40
80000501 80FFFD02 00800312 68F02003  // r1=5 r2=-3, add and dependent store
00A00412 68F00004 00900512 68F02005  // sub, and
00940612 68F00006 00980712 68F02007  // or, xor
00B00812 68F00008 00B40912 68F02009  // nand, nor
00B80A12 68F0000A 00C00B21 68F0200B  // nxor, arithmetic right shift
00C40C11 68F0000C 00200312 68F02003  // left shift, eq
00240421 68F00004 00280511 68F02005  // lt, le
002C0612 00A00762 68F00007 9000F023  // ne feeding sub, andi
68F00003 94030014 68F02004 9800FF45  // ori, xori
68F00005 68004005 68004404 48004006  // store two words, load the first back
48004407 68F02006 68F00007 48F08008  // loaded words out, key read
68F02008 80000001 80000302 80000111  // inverted keys out, counted loop
68F00001 24FFFD12 20000112 68F00000  // blt back, beq taken over a store
2C000112 28000112 68F02000 28000110  // bne not taken, ble taken, ble not taken
20000110 24000121 2C000110 68F00000  // beq and blt not taken, bne taken
80123403 68F00003 3000820E 68F0200E  // call, then link register out
68F00003 20FFFF00 80000133 68F02003  // self-branch, subroutine body
300000ED                             // return through r14

// File: tb.f
+incdir+tb
common/cpu_pkg.sv
fetch/fetch_stage.sv
decode/decode_stage.sv
execute/execute_stage.sv
verilog/mem_io_stage.sv
verilog/cpu_top.sv
tb/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the CPU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_top -f tb.f -o tb_sim
./obj_dir/tb_sim
